//--- hw/lsu_pkg.sv
// Load/store unit shared definitions

package lsu_pkg;

    // Datapath widths shared by the packed structs below
    localparam int DATA_WIDTH    = 32;
    localparam int ADDR_WIDTH    = 32;
    localparam int ROB_IDX_WIDTH = 5;

    // The picker helpers work on a fixed vector, callers use the low bits
    localparam int PICK_WIDTH     = 32;
    localparam int PICK_IDX_WIDTH = 5;

    // Store ops understood by the data cache
    typedef enum logic [1:0] {
        LSU_OP_SB = 2'b00,
        LSU_OP_SH = 2'b01,
        LSU_OP_SW = 2'b10
    } lsu_op_t;

    // Store payload, used on allocation and on the retire port
    typedef struct packed {
        lsu_op_t                  op;
        logic [ROB_IDX_WIDTH-1:0] tag;
        logic [ADDR_WIDTH-1:0]    addr;
        logic [DATA_WIDTH-1:0]    data;
    } sq_store_t;

    // Outcome of a launched store as reported by the cache side and the MHQ
    typedef struct packed {
        logic retry;
        logic replay;
        logic mhq_retry;
        logic mhq_replay;
    } sq_update_t;

    // Keeps only the lowest set bit, so index 0 has the highest priority
    function automatic logic [PICK_WIDTH-1:0] pick_lowest(input logic [PICK_WIDTH-1:0] vec);
        return vec & (~vec + PICK_WIDTH'(1));
    endfunction

    // Binary position of the set bit in a one-hot vector, zero when none is set
    function automatic logic [PICK_IDX_WIDTH-1:0] onehot_to_index(
        input logic [PICK_WIDTH-1:0] onehot
    );
        logic [PICK_IDX_WIDTH-1:0] idx;
        idx = '0;
        for (int i = 0; i < PICK_WIDTH; i++) begin
            if (onehot[i]) begin
                idx = idx | PICK_IDX_WIDTH'(i);
            end
        end
        return idx;
    endfunction

endpackage

//--- hw/lsu_sq_entry.sv
// Store queue slot

`timescale 1ns/1ns

module lsu_sq_entry (
    input  logic                                 clk,
    input  logic                                 i_reset,

    input  logic                                 i_flush,

    // Allocation of a newly issued store
    input  logic                                 i_alloc_en,
    input  lsu_pkg::sq_store_t                   i_alloc_store,

    // Launch toward the data cache
    input  logic                                 i_launch_en,

    // Result of the launch from the cache side
    input  logic                                 i_update_en,
    input  lsu_pkg::sq_update_t                  i_update,

    // Wakeup from a miss handling fill
    input  logic                                 i_mhq_fill_en,

    // ROB retirement
    input  logic                                 i_rob_retire_en,
    input  logic [lsu_pkg::ROB_IDX_WIDTH-1:0]    i_rob_retire_tag,

    output logic                                 o_empty,
    output logic                                 o_launchable,
    output logic                                 o_nonspeculative,
    output lsu_pkg::sq_store_t                   o_store,
    output logic                                 o_rob_ack
);

    typedef enum logic [2:0] {
        SQ_EMPTY      = 3'd0,
        SQ_SPEC       = 3'd1,
        SQ_LAUNCHABLE = 3'd2,
        SQ_LAUNCHED   = 3'd3,
        SQ_FILL_WAIT  = 3'd4
    } entry_state_t;

    entry_state_t       state;
    entry_state_t       state_next;
    lsu_pkg::sq_store_t store;

    logic tag_match;
    logic rob_retire;
    logic update_retry;
    logic update_replay;
    logic speculative;

    assign tag_match  = (store.tag == i_rob_retire_tag);
    assign speculative = (state == SQ_SPEC);

    // A flush in the same cycle wins over the retire, so no ack is given then
    assign rob_retire = speculative & i_rob_retire_en & tag_match & ~i_flush;

    // Either the cache or the MHQ may ask for a retry or a replay
    assign update_retry  = i_update.retry | i_update.mhq_retry;
    assign update_replay = i_update.replay | i_update.mhq_replay;

    always_comb begin
        state_next = state;

        case (state)
            SQ_EMPTY: begin
                if (i_alloc_en) begin
                    state_next = SQ_SPEC;
                end
            end
            SQ_SPEC: begin
                if (rob_retire) begin
                    state_next = SQ_LAUNCHABLE;
                end
            end
            SQ_LAUNCHABLE: begin
                if (i_launch_en) begin
                    state_next = SQ_LAUNCHED;
                end
            end
            SQ_LAUNCHED: begin
                if (i_update_en) begin
                    if (update_retry) begin
                        state_next = SQ_FILL_WAIT;
                    end else if (update_replay) begin
                        state_next = SQ_LAUNCHABLE;
                    end else begin
                        state_next = SQ_EMPTY;
                    end
                end
            end
            SQ_FILL_WAIT: begin
                if (i_mhq_fill_en) begin
                    state_next = SQ_LAUNCHABLE;
                end
            end
            default: begin
                state_next = SQ_EMPTY;
            end
        endcase

        // Speculative stores are dropped, including one being allocated right now
        if (i_flush && (state == SQ_EMPTY || state == SQ_SPEC)) begin
            state_next = SQ_EMPTY;
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            state <= SQ_EMPTY;
        end else begin
            state <= state_next;
        end
    end

    // The payload is only written when a free slot takes a new store
    always_ff @(posedge clk) begin
        if (i_alloc_en && state == SQ_EMPTY) begin
            store <= i_alloc_store;
        end
    end

    assign o_empty          = (state == SQ_EMPTY);
    assign o_launchable     = (state == SQ_LAUNCHABLE);
    assign o_nonspeculative = (state == SQ_LAUNCHABLE) |
                              (state == SQ_LAUNCHED) |
                              (state == SQ_FILL_WAIT);
    assign o_store          = store;
    assign o_rob_ack        = rob_retire;

endmodule

//--- hw/lsu_sq.sv
// Store queue

`timescale 1ns/1ns

module lsu_sq #(
    parameter int SQ_DEPTH = 8
) (
    input  logic                                 clk,
    input  logic                                 i_reset,

    input  logic                                 i_flush,
    output logic                                 o_full,
    output logic                                 o_nonspeculative_pending,

    // New store from the issue stage
    input  logic                                 i_alloc_en,
    input  lsu_pkg::sq_store_t                   i_alloc_store,

    // Retire port watched by the load queue and the cache side
    input  logic                                 i_sq_retire_stall,
    output logic                                 o_sq_retire_en,
    output logic [SQ_DEPTH-1:0]                  o_sq_retire_select,
    output lsu_pkg::sq_store_t                   o_sq_retire_store,

    // Outcome of the last launch, addressed to one slot
    input  logic                                 i_update_en,
    input  logic [SQ_DEPTH-1:0]                  i_update_select,
    input  lsu_pkg::sq_update_t                  i_update,

    // MHQ fill wakes up every store waiting on a miss
    input  logic                                 i_mhq_fill_en,

    // ROB retirement and its acknowledge
    input  logic                                 i_rob_retire_en,
    input  logic [lsu_pkg::ROB_IDX_WIDTH-1:0]    i_rob_retire_tag,
    output logic                                 o_rob_retire_ack
);

    localparam int SQ_IDX_WIDTH = (SQ_DEPTH > 1) ? $clog2(SQ_DEPTH) : 1;

    logic [SQ_DEPTH-1:0] entry_empty;
    logic [SQ_DEPTH-1:0] entry_launchable;
    logic [SQ_DEPTH-1:0] entry_nonspeculative;
    logic [SQ_DEPTH-1:0] entry_rob_ack;
    logic [SQ_DEPTH-1:0] alloc_select;
    logic [SQ_DEPTH-1:0] launch_select;
    logic [SQ_DEPTH-1:0] update_select;

    lsu_pkg::sq_store_t entry_store [SQ_DEPTH];

    logic [lsu_pkg::PICK_WIDTH-1:0]     alloc_pick;
    logic [lsu_pkg::PICK_WIDTH-1:0]     launch_pick;
    logic [lsu_pkg::PICK_IDX_WIDTH-1:0] launch_idx_full;
    logic [SQ_IDX_WIDTH-1:0]            launch_idx;
    logic                               launch_en;

    for (genvar i = 0; i < SQ_DEPTH; i++) begin : g_entry
        lsu_sq_entry lsu_sq_entry_i (
            .clk              (clk),
            .i_reset          (i_reset),
            .i_flush          (i_flush),
            .i_alloc_en       (alloc_select[i]),
            .i_alloc_store    (i_alloc_store),
            .i_launch_en      (launch_select[i]),
            .i_update_en      (update_select[i]),
            .i_update         (i_update),
            .i_mhq_fill_en    (i_mhq_fill_en),
            .i_rob_retire_en  (i_rob_retire_en),
            .i_rob_retire_tag (i_rob_retire_tag),
            .o_empty          (entry_empty[i]),
            .o_launchable     (entry_launchable[i]),
            .o_nonspeculative (entry_nonspeculative[i]),
            .o_store          (entry_store[i]),
            .o_rob_ack        (entry_rob_ack[i])
        );
    end

    assign update_select = {SQ_DEPTH{i_update_en}} & i_update_select;

    // New stores go into the lowest free slot
    assign alloc_pick   = lsu_pkg::pick_lowest(lsu_pkg::PICK_WIDTH'(entry_empty));
    assign alloc_select = {SQ_DEPTH{i_alloc_en}} & alloc_pick[SQ_DEPTH-1:0];

    // Full already accounts for the slot being taken this cycle
    assign o_full = ((entry_empty & ~alloc_select) == '0);

    assign o_nonspeculative_pending = |entry_nonspeculative;

    // Lowest launchable slot goes out, not the oldest store.
    // Nothing launches during a flush since the retire port carries no valid store then
    assign launch_pick   = lsu_pkg::pick_lowest(lsu_pkg::PICK_WIDTH'(entry_launchable));
    assign launch_select = {SQ_DEPTH{~i_sq_retire_stall & ~i_flush}} &
                           launch_pick[SQ_DEPTH-1:0];
    assign launch_en     = |launch_select;

    assign launch_idx_full = lsu_pkg::onehot_to_index(lsu_pkg::PICK_WIDTH'(launch_select));
    assign launch_idx      = launch_idx_full[SQ_IDX_WIDTH-1:0];

    // Retire port registers hold while the cache side stalls
    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_sq_retire_en <= 1'b0;
        end else if (!i_sq_retire_stall) begin
            o_sq_retire_en <= launch_en;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_sq_retire_stall) begin
            o_sq_retire_select <= launch_select;
            o_sq_retire_store  <= entry_store[launch_idx];
        end
    end

    // At most one slot matches a given ROB tag, the OR just collects it
    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_rob_retire_ack <= 1'b0;
        end else begin
            o_rob_retire_ack <= |entry_rob_ack;
        end
    end

endmodule

//--- verification/tb_clk.sv
// Testbench clock generator

`timescale 1ns/1ns

module tb_clk #(
    parameter int PERIOD = 100
) (
    output logic o_clk
);

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD / 2) o_clk = ~o_clk;
    end

endmodule

//--- verification/lsu_sq_chk.sv
// Store queue retire port assertions

`timescale 1ns/1ns

module lsu_sq_chk #(
    parameter int SQ_DEPTH = 8
) (
    input logic                  clk,
    input logic                  i_reset,
    input logic                  i_sq_retire_stall,
    input logic                  o_sq_retire_en,
    input logic [SQ_DEPTH-1:0]   o_sq_retire_select,
    input lsu_pkg::sq_store_t    o_sq_retire_store,
    input logic                  o_rob_retire_ack
);

    // A valid launch names exactly one slot
    a_select_onehot: assert property (@(posedge clk) disable iff (i_reset)
        o_sq_retire_en |-> $onehot(o_sq_retire_select))
        else $error("retire select is not one-hot while retire enable is high");

    // The cache side stall freezes the retire port
    a_stall_holds_en: assert property (@(posedge clk) disable iff (i_reset)
        i_sq_retire_stall |=> $stable(o_sq_retire_en))
        else $error("retire enable changed under stall");

    a_stall_holds_payload: assert property (@(posedge clk) disable iff (i_reset)
        (i_sq_retire_stall && o_sq_retire_en) |=>
            ($stable(o_sq_retire_select) && $stable(o_sq_retire_store)))
        else $error("retire select or store changed under stall");

    a_ack_low_after_reset: assert property (@(posedge clk)
        $past(i_reset) |-> !o_rob_retire_ack)
        else $error("ROB retire ack high right after reset");

endmodule

bind lsu_sq lsu_sq_chk #(.SQ_DEPTH(SQ_DEPTH)) lsu_sq_chk_i (.*);

//--- verification/tb_lsu_sq.sv
// Store queue testbench

`timescale 1ns/1ns

module tb_lsu_sq;

    localparam int SQ_DEPTH    = 8;
    localparam int CYCLE_LIMIT = 200;
    localparam int ST_EMPTY    = 0;
    localparam int ST_SPEC     = 1;
    localparam int ST_READY    = 2;
    localparam int ST_LAUNCHED = 3;
    localparam int ST_FILL     = 4;

    logic                              clk;
    logic                              i_reset;
    logic                              i_flush;
    logic                              i_alloc_en;
    lsu_pkg::sq_store_t                i_alloc_store;
    logic                              i_sq_retire_stall;
    logic                              i_update_en;
    logic [SQ_DEPTH-1:0]               i_update_select;
    lsu_pkg::sq_update_t               i_update;
    logic                              i_mhq_fill_en;
    logic                              i_rob_retire_en;
    logic [lsu_pkg::ROB_IDX_WIDTH-1:0] i_rob_retire_tag;
    logic                              o_full;
    logic                              o_nonspeculative_pending;
    logic                              o_sq_retire_en;
    logic [SQ_DEPTH-1:0]               o_sq_retire_select;
    lsu_pkg::sq_store_t                o_sq_retire_store;
    logic                              o_rob_retire_ack;

    // Reference model of every slot and of the registered outputs
    int                                m_state [SQ_DEPTH];
    lsu_pkg::sq_store_t                m_store [SQ_DEPTH];
    logic                              exp_retire_en;
    logic [SQ_DEPTH-1:0]               exp_select;
    lsu_pkg::sq_store_t                exp_store;
    logic                              exp_ack;
    logic                              checking;
    logic                              stall_hold;
    logic [lsu_pkg::ROB_IDX_WIDTH-1:0] next_tag;
    int                                slot;

    tb_clk #(.PERIOD(100)) tb_clk_i (.o_clk(clk));

    lsu_sq #(.SQ_DEPTH(SQ_DEPTH)) lsu_sq_i (.*);

    task automatic check_value(string name, logic [127:0] got, logic [127:0] exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
            $display("TESTS FAILED");
            $fatal(1);
        end
    endtask

    task automatic timeout_fail(string what);
        $display("Timed out after %0d cycles waiting for %s", CYCLE_LIMIT, what);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    function automatic int count_state(int st);
        int n;
        n = 0;
        for (int i = 0; i < SQ_DEPTH; i++) begin
            if (m_state[i] == st) n++;
        end
        return n;
    endfunction

    function automatic logic expected_full();
        int free_slots;
        free_slots = count_state(ST_EMPTY);
        if (i_alloc_en && free_slots > 0) free_slots--;
        return free_slots == 0;
    endfunction

    function automatic logic expected_pending();
        return (count_state(ST_READY) + count_state(ST_LAUNCHED) + count_state(ST_FILL)) > 0;
    endfunction

    // Advances the model by one clock edge using this cycle's inputs
    function void model_step();
        int   next_state [SQ_DEPTH];
        int   alloc_slot;
        int   launch_slot;
        logic ack;
        alloc_slot  = -1;
        launch_slot = -1;
        ack         = 1'b0;
        for (int i = 0; i < SQ_DEPTH; i++) begin
            if (i_alloc_en && alloc_slot < 0 && m_state[i] == ST_EMPTY) alloc_slot = i;
            if (!i_sq_retire_stall && !i_flush && launch_slot < 0 && m_state[i] == ST_READY)
                launch_slot = i;
        end
        if (!i_sq_retire_stall) begin
            exp_retire_en = (launch_slot >= 0);
            if (launch_slot >= 0) begin
                exp_select              = '0;
                exp_select[launch_slot] = 1'b1;
                exp_store               = m_store[launch_slot];
            end
        end
        for (int i = 0; i < SQ_DEPTH; i++) begin
            next_state[i] = m_state[i];
            case (m_state[i])
                ST_EMPTY: begin
                    if (i == alloc_slot) begin
                        m_store[i]    = i_alloc_store;
                        next_state[i] = i_flush ? ST_EMPTY : ST_SPEC;
                    end
                end
                ST_SPEC: begin
                    if (i_flush) begin
                        next_state[i] = ST_EMPTY;
                    end else if (i_rob_retire_en && m_store[i].tag == i_rob_retire_tag) begin
                        next_state[i] = ST_READY;
                        ack           = 1'b1;
                    end
                end
                ST_READY: if (i == launch_slot) next_state[i] = ST_LAUNCHED;
                ST_LAUNCHED: begin
                    if (i_update_en && i_update_select[i]) begin
                        if (i_update.retry || i_update.mhq_retry) next_state[i] = ST_FILL;
                        else if (i_update.replay || i_update.mhq_replay) next_state[i] = ST_READY;
                        else next_state[i] = ST_EMPTY;
                    end
                end
                default: if (i_mhq_fill_en) next_state[i] = ST_READY;
            endcase
        end
        m_state = next_state;
        exp_ack = ack;
    endfunction

    // Combinational outputs are checked late in the cycle, registered ones after the edge
    initial begin
        forever begin
            @(negedge clk);
            #40;
            if (checking) begin
                check_value("o_full", 128'(o_full), 128'(expected_full()));
                check_value("o_nonspeculative_pending", 128'(o_nonspeculative_pending),
                            128'(expected_pending()));
                model_step();
                @(posedge clk);
                #10;
                check_value("o_sq_retire_en", 128'(o_sq_retire_en), 128'(exp_retire_en));
                check_value("o_rob_retire_ack", 128'(o_rob_retire_ack), 128'(exp_ack));
                if (exp_retire_en) begin
                    check_value("o_sq_retire_select", 128'(o_sq_retire_select), 128'(exp_select));
                    check_value("o_sq_retire_store", 128'(o_sq_retire_store), 128'(exp_store));
                end
            end
        end
    end

    task automatic idle_inputs();
        i_flush           = 1'b0;
        i_alloc_en        = 1'b0;
        i_alloc_store     = '0;
        i_sq_retire_stall = stall_hold;
        i_update_en       = 1'b0;
        i_update_select   = '0;
        i_update          = '0;
        i_mhq_fill_en     = 1'b0;
        i_rob_retire_en   = 1'b0;
        i_rob_retire_tag  = '0;
    endtask

    task automatic next_cycle();
        @(negedge clk);
        idle_inputs();
    endtask

    function automatic lsu_pkg::sq_store_t make_store(logic [lsu_pkg::ROB_IDX_WIDTH-1:0] tag);
        lsu_pkg::sq_store_t s;
        s.op   = lsu_pkg::lsu_op_t'(2'($urandom_range(0, 2)));
        s.tag  = tag;
        s.addr = $urandom;
        s.data = $urandom;
        return s;
    endfunction

    task automatic alloc_store(logic [lsu_pkg::ROB_IDX_WIDTH-1:0] tag);
        i_alloc_en    = 1'b1;
        i_alloc_store = make_store(tag);
        next_cycle();
    endtask

    task automatic retire_tag(logic [lsu_pkg::ROB_IDX_WIDTH-1:0] tag);
        i_rob_retire_en  = 1'b1;
        i_rob_retire_tag = tag;
        next_cycle();
    endtask

    task automatic send_update(int idx, logic retry, logic replay);
        i_update_en          = 1'b1;
        i_update_select      = SQ_DEPTH'(1) << idx;
        i_update.retry       = retry;
        i_update.replay      = replay;
        next_cycle();
    endtask

    // Returns the slot named on the retire port once a launch shows up
    task automatic wait_launch(output int idx);
        int n;
        n = 0;
        while (!o_sq_retire_en) begin
            if (n == CYCLE_LIMIT) timeout_fail("a store launch");
            next_cycle();
            n++;
        end
        idx = 0;
        for (int i = 0; i < SQ_DEPTH; i++) begin
            if (o_sq_retire_select[i]) idx = i;
        end
    endtask

    task automatic random_cycle();
        int pick;
        i_sq_retire_stall = ($urandom_range(0, 9) < 2);
        if (count_state(ST_EMPTY) > 0 && $urandom_range(0, 1) == 1) begin
            i_alloc_en    = 1'b1;
            i_alloc_store = make_store(next_tag);
            next_tag++;
        end
        pick = $urandom_range(0, SQ_DEPTH - 1);
        if (m_state[pick] == ST_SPEC && $urandom_range(0, 1) == 1) begin
            i_rob_retire_en  = 1'b1;
            i_rob_retire_tag = m_store[pick].tag;
        end
        pick = $urandom_range(0, SQ_DEPTH - 1);
        if (m_state[pick] == ST_LAUNCHED && $urandom_range(0, 2) == 0) begin
            i_update_en     = 1'b1;
            i_update_select = SQ_DEPTH'(1) << pick;
            case ($urandom_range(0, 5))
                1: i_update.replay     = 1'b1;
                2: i_update.mhq_retry  = 1'b1;
                3: i_update.retry      = 1'b1;
                4: i_update.mhq_replay = 1'b1;
                default: i_update      = '0;
            endcase
        end
        i_mhq_fill_en = ($urandom_range(0, 9) == 0);
        i_flush       = ($urandom_range(0, 49) == 0);
        next_cycle();
    endtask

    initial begin
        void'($urandom(62));
        stall_hold = 1'b0;
        checking   = 1'b0;
        next_tag   = '0;
        i_reset    = 1'b1;
        idle_inputs();
        for (int i = 0; i < SQ_DEPTH; i++) m_state[i] = ST_EMPTY;
        exp_retire_en = 1'b0;
        exp_select    = '0;
        exp_store     = '0;
        exp_ack       = 1'b0;
        repeat (10) @(negedge clk);
        i_reset  = 1'b0;
        checking = 1'b1;

        // Fill the queue, then retire and complete slot 0 to clear full
        for (int t = 0; t < SQ_DEPTH; t++) alloc_store(5'(t));
        retire_tag(5'd0);
        wait_launch(slot);
        check_value("first launch slot", 128'(slot), 128'(0));
        send_update(slot, 1'b0, 1'b0);
        #20;
        check_value("o_full after free", 128'(o_full), 128'(0));

        // Two retires under stall and the lower slot goes first once it drops
        stall_hold = 1'b1;
        next_cycle();
        retire_tag(5'd3);
        retire_tag(5'd1);
        repeat (4) next_cycle();
        stall_hold = 1'b0;
        next_cycle();
        wait_launch(slot);
        check_value("launch after stall", 128'(slot), 128'(1));

        // Replay slot 1, send slot 3 to wait for a fill, then free slot 1
        send_update(1, 1'b0, 1'b1);
        send_update(3, 1'b1, 1'b0);
        wait_launch(slot);
        check_value("replayed slot", 128'(slot), 128'(1));
        send_update(1, 1'b0, 1'b0);

        // Flush leaves only the fill-waiting store
        i_flush = 1'b1;
        next_cycle();
        check_value("pending after flush", 128'(o_nonspeculative_pending), 128'(1));
        i_mhq_fill_en = 1'b1;
        next_cycle();
        wait_launch(slot);
        check_value("slot after fill", 128'(slot), 128'(3));
        send_update(3, 1'b0, 1'b0);
        next_cycle();
        check_value("pending when drained", 128'(o_nonspeculative_pending), 128'(0));

        repeat (2000) random_cycle();
        repeat (4) next_cycle();

        $display("TESTS PASSED");
        $finish;
    end

endmodule

//--- lsu_sq.f
hw/lsu_pkg.sv
hw/lsu_sq_entry.sv
hw/lsu_sq.sv
verification/tb_clk.sv
verification/lsu_sq_chk.sv
verification/tb_lsu_sq.sv

//--- run.sh
#!/bin/sh
# Builds the store queue testbench with Verilator and runs it.
# The exit status is the simulator's, so a failed run returns non-zero.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f lsu_sq.f \
    --top-module tb_lsu_sq \
    -Mdir build \
    -o sim_tb_lsu_sq
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./build/sim_tb_lsu_sq
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi

exit 0
